// ==== hw/bpc_block_collector.sv ====
// blocks must be exactly 16 beats with sop on the first and eop on the last; no error recovery
module bpc_block_collector
    import bpc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [BEAT_W-1:0]         data_i,
    input  logic                      valid_i,
    input  logic                      sop_i,
    input  logic                      eop_i,
    input  logic                      blk_ready_i,
    output logic                      ready_o,
    output logic                      blk_valid_o,
    output logic [PLANES*PLANE_W-1:0] blk_planes_o,
    output logic [WORD_W-1:0]         blk_base_o
);

    logic                                    accept;
    logic [BEAT_CNT_W-1:0]                   cnt_q;
    logic [BEAT_CNT_W-1:0]                   beat_idx;
    logic                                    blk_valid_q;
    logic [WORD_W-1:0]                       base_q;
    logic [WORD_W-1:0]                       cur_base;
    logic [WORDS_PER_BEAT-1:0][WORD_W-1:0]   delta;
    logic [PLANES*PLANE_W-1:0]               planes_q;

    // no new beats while a finished block waits for handover
    assign ready_o  = !blk_valid_q;
    assign accept   = valid_i && ready_o;

    // the sop beat carries its own base in the top word
    assign cur_base = sop_i ? data_i[BEAT_W-1 -: WORD_W] : base_q;
    assign beat_idx = sop_i ? '0 : cnt_q;

    always_comb begin
        for (int w = 0; w < WORDS_PER_BEAT; w++) begin
            delta[w] = data_i[BEAT_W-1-w*WORD_W -: WORD_W] - cur_base;
        end
    end

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q       <= '0;
            blk_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                if (eop_i) begin
                    cnt_q <= '0;
                end else begin
                    cnt_q <= beat_idx + 1'b1;
                end
            end
            if (accept && eop_i) begin
                blk_valid_q <= 1'b1;
            end else if (blk_ready_i) begin
                blk_valid_q <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // base word and transposed plane store
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept && sop_i) begin
            base_q <= data_i[BEAT_W-1 -: WORD_W];
        end
        if (accept) begin
            // delta d is word d+1 of the block
            for (int d = 0; d < PLANE_W; d++) begin
                if (beat_idx == BEAT_CNT_W'((d + 1) / WORDS_PER_BEAT)) begin
                    for (int j = 0; j < WORD_W; j++) begin
                        // msb of delta lands in plane 0, delta 0 in plane bit 62
                        planes_q[(PLANES-1-j)*PLANE_W + (PLANE_W-1-d)] <=
                            delta[(d + 1) % WORDS_PER_BEAT][j];
                    end
                end
            end
        end
    end

    assign blk_valid_o  = blk_valid_q;
    assign blk_planes_o = planes_q;
    assign blk_base_o   = base_q;

endmodule

// ==== hw/bpc_encoder_top.sv ====
// holds up to two blocks in flight; header follows the eop input beat by 2 cycles when idle
module bpc_encoder_top
    import bpc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [BEAT_W-1:0]   data_i,
    input  logic                valid_i,
    input  logic                sop_i,
    input  logic                eop_i,
    output logic                ready_o,
    output logic [SYMBOL_W-1:0] data_o,
    output logic [SIZE_W-1:0]   size_o,
    output logic                valid_o,
    output logic                sop_o,
    output logic                eop_o,
    input  logic                ready_i
);

    logic                      blk_valid;
    logic                      blk_ready;
    logic [PLANES*PLANE_W-1:0] blk_planes;
    logic [WORD_W-1:0]         blk_base;

    logic [PLANE_W-1:0]        xplane;
    logic                      plane_zero;
    logic                      code_zero;
    logic [CODE_W-1:0]         code;
    logic [SIZE_W-1:0]         code_size;

    bpc_block_collector u_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_i       (data_i),
        .valid_i      (valid_i),
        .sop_i        (sop_i),
        .eop_i        (eop_i),
        .blk_ready_i  (blk_ready),
        .ready_o      (ready_o),
        .blk_valid_o  (blk_valid),
        .blk_planes_o (blk_planes),
        .blk_base_o   (blk_base)
    );

    bpc_plane_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .blk_valid_i  (blk_valid),
        .blk_planes_i (blk_planes),
        .blk_base_i   (blk_base),
        .ready_i      (ready_i),
        .zero_i       (code_zero),
        .code_i       (code),
        .size_i       (code_size),
        .blk_ready_o  (blk_ready),
        .xplane_o     (xplane),
        .plane_zero_o (plane_zero),
        .data_o       (data_o),
        .size_o       (size_o),
        .valid_o      (valid_o),
        .sop_o        (sop_o),
        .eop_o        (eop_o)
    );

    bpc_plane_coder u_coder (
        .xplane_i     (xplane),
        .plane_zero_i (plane_zero),
        .zero_o       (code_zero),
        .code_o       (code),
        .size_o       (code_size)
    );

endmodule

// ==== hw/bpc_pkg.sv ====
// geometry fixed at 64 words of 16 bits per block; changing a width here alone is not supported
package bpc_pkg;

    // ------------------------------------------------------------------------
    // data and block geometry
    // ------------------------------------------------------------------------
    localparam int WORD_W          = 16;
    localparam int WORDS_PER_BEAT  = 4;
    localparam int BEAT_W          = WORD_W * WORDS_PER_BEAT;
    localparam int BEATS_PER_BLOCK = 16;
    localparam int BEAT_CNT_W      = 4;

    // one plane per delta bit, one plane bit per delta
    localparam int PLANES  = WORD_W;
    localparam int PLANE_W = WORDS_PER_BEAT * BEATS_PER_BLOCK - 1;
    localparam int POS_W   = 6;

    // ------------------------------------------------------------------------
    // symbol widths
    // ------------------------------------------------------------------------
    localparam int CODE_W   = PLANE_W + 1;
    localparam int SIZE_W   = 7;
    localparam int RUN_W    = 4;
    // run prefix 6 bits plus widest codeword
    localparam int SYMBOL_W = 6 + CODE_W;
    // two zero bits then the base word
    localparam int HEADER_W = 2 + WORD_W;

    // ------------------------------------------------------------------------
    // symbol prefixes
    // ------------------------------------------------------------------------
    localparam logic [4:0] PFX_ALL_ONES = 5'b00000;
    localparam logic [4:0] PFX_DBP_ZERO = 5'b00001;
    localparam logic [4:0] PFX_PAIR     = 5'b00010;
    localparam logic [4:0] PFX_SINGLE   = 5'b00011;
    localparam logic [2:0] PFX_RUN1     = 3'b001;
    localparam logic [1:0] PFX_RUN      = 2'b01;

endpackage

// ==== hw/bpc_plane_coder.sv ====
// purely combinational; codeword is left-aligned and bits below size_o are zero
module bpc_plane_coder
    import bpc_pkg::*;
(
    input  logic [PLANE_W-1:0] xplane_i,
    input  logic               plane_zero_i,
    output logic               zero_o,
    output logic [CODE_W-1:0]  code_o,
    output logic [SIZE_W-1:0]  size_o
);

    logic [PLANE_W-1:0] lsb;
    logic [POS_W-1:0]   pos;
    logic               is_single;
    logic               is_pair;

    // isolate the lowest set bit
    assign lsb = xplane_i & (~xplane_i + 1'b1);

    always_comb begin
        pos = '0;
        for (int i = 0; i < PLANE_W; i++) begin
            if (lsb[i]) begin
                pos = POS_W'(i);
            end
        end
    end

    assign is_single = (xplane_i == lsb);
    // a pair needs room for the upper bit
    assign is_pair   = !lsb[PLANE_W-1] && (xplane_i == (lsb | (lsb << 1)));

    // ------------------------------------------------------------------------
    // classification in priority order
    // ------------------------------------------------------------------------
    always_comb begin
        zero_o = 1'b0;
        code_o = '0;
        size_o = '0;
        if (xplane_i == '0) begin
            zero_o = 1'b1;
        end else if (&xplane_i) begin
            code_o = {PFX_ALL_ONES, {(CODE_W-$bits(PFX_ALL_ONES)){1'b0}}};
            size_o = SIZE_W'($bits(PFX_ALL_ONES));
        end else if (plane_zero_i) begin
            code_o = {PFX_DBP_ZERO, {(CODE_W-$bits(PFX_DBP_ZERO)){1'b0}}};
            size_o = SIZE_W'($bits(PFX_DBP_ZERO));
        end else if (is_pair) begin
            code_o = {PFX_PAIR, pos, {(CODE_W-$bits(PFX_PAIR)-POS_W){1'b0}}};
            size_o = SIZE_W'($bits(PFX_PAIR) + POS_W);
        end else if (is_single) begin
            code_o = {PFX_SINGLE, pos, {(CODE_W-$bits(PFX_SINGLE)-POS_W){1'b0}}};
            size_o = SIZE_W'($bits(PFX_SINGLE) + POS_W);
        end else begin
            // uncompressed plane behind a marker bit
            code_o = {1'b1, xplane_i};
            size_o = SIZE_W'(CODE_W);
        end
    end

endmodule

// ==== hw/bpc_plane_sequencer.sv ====
// one plane per cycle while the output register is free; coder results must settle in the same cycle
module bpc_plane_sequencer
    import bpc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      blk_valid_i,
    input  logic [PLANES*PLANE_W-1:0] blk_planes_i,
    input  logic [WORD_W-1:0]         blk_base_i,
    input  logic                      ready_i,
    input  logic                      zero_i,
    input  logic [CODE_W-1:0]         code_i,
    input  logic [SIZE_W-1:0]         size_i,
    output logic                      blk_ready_o,
    output logic [PLANE_W-1:0]        xplane_o,
    output logic                      plane_zero_o,
    output logic [SYMBOL_W-1:0]       data_o,
    output logic [SIZE_W-1:0]         size_o,
    output logic                      valid_o,
    output logic                      sop_o,
    output logic                      eop_o
);

    logic [PLANES*PLANE_W-1:0]   planes_q;
    logic                        busy_q;
    logic                        walk_q;
    logic [BEAT_CNT_W-1:0]       idx_q;
    logic [BEAT_CNT_W-1:0]       prev_idx;
    logic [RUN_W:0]              run_q;
    logic [RUN_W:0]              run_eff;
    logic [RUN_W-1:0]            run_field;
    logic [PLANE_W-1:0]          cur_plane;
    logic [PLANE_W-1:0]          prev_plane;

    logic [SYMBOL_W-CODE_W-1:0]  pfx;
    logic [SIZE_W-1:0]           pfx_size;
    logic [SYMBOL_W-1:0]         sym_data;
    logic [SIZE_W-1:0]           sym_size;
    logic [SYMBOL_W-1:0]         hdr_data;

    logic                        out_free;
    logic                        last_plane;
    logic                        load;
    logic                        step;
    logic                        emit;

    logic [SYMBOL_W-1:0]         data_q;
    logic [SIZE_W-1:0]           size_q;
    logic                        valid_q;
    logic                        sop_q;
    logic                        eop_q;

    // ------------------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------------------
    assign out_free    = !valid_q || ready_i;
    assign blk_ready_o = !busy_q || (valid_q && eop_q && ready_i);
    assign load        = blk_valid_i && blk_ready_o;
    assign last_plane  = (idx_q == BEAT_CNT_W'(PLANES - 1));
    assign step        = walk_q && out_free;
    // zero planes only emit when they close the block
    assign emit        = load || (step && (!zero_i || last_plane));

    // ------------------------------------------------------------------------
    // xor plane towards the coder
    // ------------------------------------------------------------------------
    assign prev_idx     = idx_q - 1'b1;
    assign cur_plane    = planes_q[idx_q*PLANE_W +: PLANE_W];
    assign prev_plane   = planes_q[prev_idx*PLANE_W +: PLANE_W];
    assign xplane_o     = (idx_q == '0) ? cur_plane : (prev_plane ^ cur_plane);
    assign plane_zero_o = (cur_plane == '0);

    // ------------------------------------------------------------------------
    // symbol assembly
    // ------------------------------------------------------------------------
    // a zero plane here is the last one and joins the pending run
    assign run_eff   = zero_i ? run_q + 1'b1 : run_q;
    assign run_field = RUN_W'(run_eff - 2'd2);

    always_comb begin
        if (run_eff == '0) begin
            pfx      = '0;
            pfx_size = '0;
        end else if (run_eff == 1) begin
            pfx      = {PFX_RUN1, {(SYMBOL_W-CODE_W-$bits(PFX_RUN1)){1'b0}}};
            pfx_size = SIZE_W'($bits(PFX_RUN1));
        end else begin
            pfx      = {PFX_RUN, run_field};
            pfx_size = SIZE_W'(SYMBOL_W - CODE_W);
        end
    end

    // coder gives code zero and size zero on a zero plane
    assign sym_data = {pfx, {CODE_W{1'b0}}} |
                      ({code_i, {(SYMBOL_W-CODE_W){1'b0}}} >> pfx_size);
    assign sym_size = pfx_size + size_i;
    assign hdr_data = {{(HEADER_W-WORD_W){1'b0}}, blk_base_i, {(SYMBOL_W-HEADER_W){1'b0}}};

    // ------------------------------------------------------------------------
    // walk control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            walk_q <= 1'b0;
            idx_q  <= '0;
            run_q  <= '0;
        end else if (load) begin
            busy_q <= 1'b1;
            walk_q <= 1'b1;
            idx_q  <= '0;
            run_q  <= '0;
        end else begin
            if (valid_q && eop_q && ready_i) begin
                busy_q <= 1'b0;
            end
            if (step) begin
                idx_q <= idx_q + 1'b1;
                run_q <= zero_i ? run_q + 1'b1 : '0;
                if (last_plane) begin
                    walk_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            planes_q <= blk_planes_i;
        end
    end

    // ------------------------------------------------------------------------
    // output register, held while stalled
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            sop_q   <= 1'b0;
            eop_q   <= 1'b0;
        end else if (out_free) begin
            valid_q <= emit;
            sop_q   <= load;
            eop_q   <= !load && step && last_plane;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free && emit) begin
            data_q <= load ? hdr_data : sym_data;
            size_q <= load ? SIZE_W'(HEADER_W) : sym_size;
        end
    end

    assign data_o  = data_q;
    assign size_o  = size_q;
    assign valid_o = valid_q;
    assign sop_o   = sop_q;
    assign eop_o   = eop_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with Verilator, run the testbench, decide from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module bpc_tb; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vbpc_tb > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

// ==== verif/bpc_assertions.sv ====
// bound into the plane sequencer; checks output protocol only, not symbol contents
module bpc_assertions
    import bpc_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                valid_o,
    input logic                ready_i,
    input logic [SYMBOL_W-1:0] data_o,
    input logic [SIZE_W-1:0]   size_o,
    input logic                sop_o,
    input logic                eop_o
);

    logic in_block;

    // open from the header transfer to the eop transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_block <= 1'b0;
        end else if (valid_o && ready_i) begin
            if (eop_o) begin
                in_block <= 1'b0;
            end else if (sop_o) begin
                in_block <= 1'b1;
            end
        end
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o) && $stable(size_o) &&
                                   $stable(sop_o) && $stable(eop_o)))
        else $error("output changed while stalled");

    a_sop_valid: assert property (@(posedge clk) disable iff (!rst_n) sop_o |-> valid_o)
        else $error("sop_o high without valid_o");

    a_one_header: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_o && sop_o) |-> !in_block)
        else $error("second header before eop_o");

endmodule

// ==== verif/bpc_ref_model.svh ====
// needs push_beat and the expected queues of the including module; models one block per call
`ifndef BPC_REF_MODEL_SVH
`define BPC_REF_MODEL_SVH

// header symbol: two zero bits then the base word
function automatic void push_header(input logic [WORD_W-1:0] base);
    push_beat({2'b00, base, {(SYMBOL_W-HEADER_W){1'b0}}}, SIZE_W'(HEADER_W), 1'b1, 1'b0);
endfunction

// codeword of one xor plane, left-aligned, len 0 for a zero plane
function automatic void code_plane(input logic [PLANE_W-1:0] xp, input logic src_zero,
                                   output logic [CODE_W-1:0] code, output int len);
    int ones;
    int lo;
    ones = 0;
    lo   = 0;
    for (int i = PLANE_W - 1; i >= 0; i--) begin
        if (xp[i]) begin
            ones++;
            lo = i;
        end
    end
    code = '0;
    len  = 0;
    if (ones == PLANE_W) begin
        code[CODE_W-1 -: 5] = PFX_ALL_ONES;
        len = 5;
    end else if (ones != 0 && src_zero) begin
        code[CODE_W-1 -: 5] = PFX_DBP_ZERO;
        len = 5;
    end else if (ones == 2 && lo < PLANE_W - 1 && xp[lo+1]) begin
        code[CODE_W-1 -: 11] = {PFX_PAIR, POS_W'(lo)};
        len = 11;
    end else if (ones == 1) begin
        code[CODE_W-1 -: 11] = {PFX_SINGLE, POS_W'(lo)};
        len = 11;
    end else if (ones != 0) begin
        code = {1'b1, xp};
        len  = CODE_W;
    end
endfunction

function automatic void expect_block(input logic [WORD_W-1:0] words [64]);
    logic [WORD_W-1:0]   d;
    logic [PLANE_W-1:0]  plane [PLANES];
    logic [PLANE_W-1:0]  xp;
    logic [CODE_W-1:0]   code;
    logic [SYMBOL_W-1:0] sym;
    int                  len;
    int                  at;
    int                  run;
    // delta k is word k+1; its msb goes to plane 0 at bit 62-k
    for (int k = 0; k < PLANE_W; k++) begin
        d = words[k+1] - words[0];
        for (int i = 0; i < PLANES; i++) begin
            plane[i][PLANE_W-1-k] = d[WORD_W-1-i];
        end
    end
    push_header(words[0]);
    run = 0;
    for (int i = 0; i < PLANES; i++) begin
        xp = (i == 0) ? plane[0] : (plane[i-1] ^ plane[i]);
        code_plane(xp, plane[i] == '0, code, len);
        if (len == 0) begin
            run++;
        end
        // last plane always closes the block, either with a code or a trailing run
        if (len != 0 || (i == PLANES - 1 && run != 0)) begin
            sym = '0;
            at  = 0;
            if (run == 1) begin
                sym[SYMBOL_W-1 -: 3] = PFX_RUN1;
                at = 3;
            end else if (run > 1) begin
                sym[SYMBOL_W-1 -: 6] = {PFX_RUN, RUN_W'(run - 2)};
                at = 6;
            end
            sym = sym | ({code, {(SYMBOL_W-CODE_W){1'b0}}} >> at);
            push_beat(sym, SIZE_W'(at + len), 1'b0, i == PLANES - 1);
            run = 0;
        end
    end
endfunction

`endif

// ==== verif/bpc_tb.sv ====
// directed tests for the encoder; one block is driven at a time and beats must arrive in order
module bpc_tb
    import bpc_pkg::*;
();

    localparam int RANDOM_BLOCKS = 8;
    localparam int STREAM_BLOCKS = 6;
    localparam int TOTAL_BLOCKS  = 18 + RANDOM_BLOCKS + STREAM_BLOCKS;
    localparam int LIMIT_CYCLES  = TOTAL_BLOCKS * 64 + 200;

    logic                clk;
    logic                rst_n;
    logic [BEAT_W-1:0]   data_i;
    logic                valid_i;
    logic                sop_i;
    logic                eop_i;
    logic                ready_o;
    logic [SYMBOL_W-1:0] data_o;
    logic [SIZE_W-1:0]   size_o;
    logic                valid_o;
    logic                sop_o;
    logic                eop_o;
    logic                ready_i;

    int                  seed = 32'h0712_4693;
    int                  errors = 0;
    int                  beats = 0;
    bit                  backpressure = 1'b0;
    int                  low_run = 0;
    int                  max_low_run = 0;
    logic [WORD_W-1:0]   blk_words [64];
    logic [SYMBOL_W-1:0] exp_data [$];
    logic [SIZE_W-1:0]   exp_size [$];
    logic                exp_sop [$];
    logic                exp_eop [$];

    bpc_encoder_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .data_i  (data_i),
        .valid_i (valid_i),
        .sop_i   (sop_i),
        .eop_i   (eop_i),
        .ready_o (ready_o),
        .data_o  (data_o),
        .size_o  (size_o),
        .valid_o (valid_o),
        .sop_o   (sop_o),
        .eop_o   (eop_o),
        .ready_i (ready_i)
    );

    bind bpc_plane_sequencer bpc_assertions u_assertions (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .data_o  (data_o),
        .size_o  (size_o),
        .sop_o   (sop_o),
        .eop_o   (eop_o)
    );

    function automatic void push_beat(input logic [SYMBOL_W-1:0] d, input logic [SIZE_W-1:0] s,
                                      input logic sop, input logic eop);
        exp_data.push_back(d);
        exp_size.push_back(s);
        exp_sop.push_back(sop);
        exp_eop.push_back(eop);
    endfunction

    `include "bpc_ref_model.svh"

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_symbol(input logic [SYMBOL_W-1:0] exp_d, input logic [SIZE_W-1:0] exp_s,
                                input logic [SYMBOL_W-1:0] act_d, input logic [SIZE_W-1:0] act_s);
        if (act_d !== exp_d || act_s !== exp_s) begin
            errors++;
            $display("FAIL %0t: symbol %h size %0d, expected %h size %0d",
                     $time, act_d, act_s, exp_d, exp_s);
        end
    endtask

    task automatic check_framing(input logic exp_sop_b, input logic exp_eop_b,
                                 input logic act_sop_b, input logic act_eop_b);
        if (act_sop_b !== exp_sop_b || act_eop_b !== exp_eop_b) begin
            errors++;
            $display("FAIL %0t: sop/eop %b%b, expected %b%b",
                     $time, act_sop_b, act_eop_b, exp_sop_b, exp_eop_b);
        end
    endtask

    task automatic take_beat();
        if (exp_data.size() == 0) begin
            errors++;
            $display("an output beat arrived at %0t when none was expected", $time);
        end else begin
            check_symbol(exp_data.pop_front(), exp_size.pop_front(), data_o, size_o);
            check_framing(exp_sop.pop_front(), exp_eop.pop_front(), sop_o, eop_o);
        end
        beats++;
    endtask

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic void fill_flat(input logic [WORD_W-1:0] value);
        foreach (blk_words[k]) begin
            blk_words[k] = value;
        end
    endfunction

    function automatic void fill_random(input logic [WORD_W-1:0] mask);
        logic [WORD_W-1:0] base;
        base = 16'($random(seed));
        foreach (blk_words[k]) begin
            blk_words[k] = base + (16'($random(seed)) & mask);
        end
        blk_words[0] = base;
    endfunction

    // called on a falling edge; ready_o only moves on the rising edge
    task automatic drive_block();
        for (int b = 0; b < BEATS_PER_BLOCK; b++) begin
            data_i  = {blk_words[4*b], blk_words[4*b+1], blk_words[4*b+2], blk_words[4*b+3]};
            valid_i = 1'b1;
            sop_i   = (b == 0);
            eop_i   = (b == BEATS_PER_BLOCK - 1);
            while (!ready_o) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        valid_i = 1'b0;
        sop_i   = 1'b0;
        eop_i   = 1'b0;
    endtask

    task automatic send_block();
        expect_block(blk_words);
        drive_block();
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_and_flat();
        if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
            errors++;
            $display("FAIL %0t: after reset valid_o %b ready_o %b, expected 0 and 1",
                     $time, valid_o, ready_o);
        end
        fill_flat(16'hA5C3);
        push_header(16'hA5C3);
        // sixteen zero planes give run field 14
        push_beat({PFX_RUN, 4'd14, {CODE_W{1'b0}}}, 7'd6, 1'b0, 1'b1);
        drive_block();
        wait_drain();
    endtask

    task automatic test_single_pair();
        logic [WORD_W-1:0] base;
        base = 16'h3C5A;
        // delta 4 is 1, so only xor plane 15 is set, at bit 58
        fill_flat(base);
        blk_words[5] = base + 16'd1;
        push_header(base);
        push_beat({PFX_RUN, 4'd13, PFX_SINGLE, 6'd58, {(SYMBOL_W-17){1'b0}}}, 7'd17, 1'b0, 1'b1);
        drive_block();
        for (int j = 0; j < WORD_W; j += 5) begin
            fill_flat(base);
            blk_words[4*j+1] = base + (16'd1 << j);
            send_block();
            // two neighbours with the same delta make a pair
            fill_flat(base);
            blk_words[2*j+7] = base + (16'd1 << j);
            blk_words[2*j+8] = base + (16'd1 << j);
            send_block();
            fill_flat(base);
            blk_words[63-j] = base + (16'd3 << j);
            send_block();
        end
        wait_drain();
    endtask

    task automatic test_other_classes();
        // msb in every delta gives all-ones planes
        fill_flat(16'h9234);
        blk_words[0] = 16'h1234;
        send_block();
        // one zero plane ahead, then a plane whose source is zero
        fill_flat(16'h0F0F);
        blk_words[40] = 16'h4F0F;
        send_block();
        foreach (blk_words[k]) begin
            blk_words[k] = 16'(k * 16'h1357);
        end
        send_block();
        foreach (blk_words[k]) begin
            blk_words[k] = k[0] ? 16'hFFFF : 16'h0000;
        end
        send_block();
        wait_drain();
    endtask

    task automatic test_random();
        for (int n = 0; n < RANDOM_BLOCKS; n++) begin
            fill_random(16'hFFFF >> (2 * n));
            send_block();
        end
        wait_drain();
    endtask

    task automatic test_stream();
        backpressure = 1'b1;
        max_low_run  = 0;
        for (int n = 0; n < STREAM_BLOCKS; n++) begin
            fill_random(16'hFFFF);
            send_block();
        end
        wait_drain();
        backpressure = 1'b0;
        if (max_low_run < 3) begin
            errors++;
            $display("ready_o never stayed low while two blocks were pending");
        end
    endtask

    // ------------------------------------------------------------------------
    // clock, output side, watchdog, main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ready_i and beat checking share one process so each beat is seen once
    initial begin
        ready_i = 1'b1;
        forever begin
            @(negedge clk);
            ready_i = backpressure ? 1'($random(seed)) : 1'b1;
            if (rst_n && valid_o && ready_i) begin
                take_beat();
            end
            if (rst_n && !ready_o) begin
                low_run++;
                if (low_run > max_low_run) begin
                    max_low_run = low_run;
                end
            end else begin
                low_run = 0;
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d beats still expected",
                 LIMIT_CYCLES, exp_data.size());
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        data_i  = '0;
        valid_i = 1'b0;
        sop_i   = 1'b0;
        eop_i   = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        test_reset_and_flat();
        test_single_pair();
        test_other_classes();
        test_random();
        test_stream();
        repeat (20) @(negedge clk);
        $display("errors: %0d, beats checked: %0d, beats missing: %0d",
                 errors, beats, exp_data.size());
        if (errors == 0 && exp_data.size() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verif
hw/bpc_pkg.sv
hw/bpc_block_collector.sv
hw/bpc_plane_coder.sv
hw/bpc_plane_sequencer.sv
hw/bpc_encoder_top.sv
verif/bpc_assertions.sv
verif/bpc_tb.sv
